/* Makefile */
# Verilator build for the register-address path

VERILATOR  ?= verilator
FILELIST   ?= files.f
TOP        ?= addressPathTb
RTL_TOP    ?= addressPath
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= RESULT: PASS

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Fails unless the pass line shows up in the simulation output
run: build
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
hdl/instrPkg.sv
hdl/regBankPkg.sv
hdl/regSelect.sv
hdl/bankDecode.sv
hdl/addrPipe.sv
hdl/hazardMatch.sv
hdl/addressPath.sv
tb/addressPathTb.sv

/* hdl/addrPipe.sv */
`timescale 1ns/1ps

module addrPipe (
  input  logic                   clk,
  input  logic                   rst,
  input  regBankPkg::stageAddrT  addrD,
  input  logic                   stallE,
  input  logic                   stallM,
  input  logic                   flushM,
  input  logic                   stallW,
  input  logic                   flushW,
  output regBankPkg::stageAddrT  addrE,
  output regBankPkg::physAddrT   wa3M,
  output regBankPkg::physAddrT   wa3W
);

  // ====================
  // Execute stage
  // ====================

  // Read lines travel on for the E to W compares
  // Write line feeds the D to E compares
  // Stall holds the instruction in E, no flush here
  always_ff @(posedge clk) begin
    if (rst) begin
      addrE <= '0;
    end else if (!stallE) begin
      addrE <= addrD;
    end
  end

  // ====================
  // Memory stage
  // ====================

  // Only the write line goes further
  // Flush wins over stall and leaves a bubble
  always_ff @(posedge clk) begin
    if (rst) begin
      wa3M <= '0;
    end else if (flushM) begin
      wa3M <= '0;
    end else if (!stallM) begin
      wa3M <= addrE.wa3;
    end
  end

  // ====================
  // Writeback stage
  // ====================

  // Line that strobes the register file write
  // A zero line writes nothing and matches nothing
  always_ff @(posedge clk) begin
    if (rst) begin
      wa3W <= '0;
    end else if (flushW) begin
      wa3W <= '0;
    end else if (!stallW) begin
      wa3W <= wa3M;
    end
  end

  // Stages move on their own enables
  // A stalled E with a running M inserts a copy, which the
  // hazard unit turns into a bubble through flushM
  // Up to three instructions share the path at any time

endmodule

/* hdl/addressPath.sv */
`timescale 1ns/1ps

module addressPath (
  input  logic                  clk,
  input  logic                  rst,
  // Controller side
  input  instrPkg::instrWordT   instrD,
  input  instrPkg::regCtrlT     ctrlD,
  // Current mode from the CPSR
  input  regBankPkg::modeT      cpsrModeW,
  // Hazard unit levels
  input  logic                  stallE,
  input  logic                  stallM,
  input  logic                  flushM,
  input  logic                  stallW,
  input  logic                  flushW,
  // Register file lines
  output regBankPkg::physAddrT  ra1D,
  output regBankPkg::physAddrT  ra2D,
  output regBankPkg::physAddrT  wa3W,
  // Hazard unit strobes
  output logic                  match1DE,
  output logic                  match2DE,
  output logic                  match1EM,
  output logic                  match2EM,
  output logic                  match1EW,
  output logic                  match2EW
);

  import regBankPkg::*;

  logic [3:0] ra1Num;
  logic [3:0] ra2Num;
  logic [3:0] wa3Num;
  stageAddrT  addrD;
  stageAddrT  addrE;

  // ====================
  // Decode
  // ====================

  regSelect regSel (
    .instrD (instrD),
    .ctrlD  (ctrlD),
    .ra1Num (ra1Num),
    .ra2Num (ra2Num),
    .wa3Num (wa3Num),
    .regR2  (addrD.regR2)
  );

  // One decoder per port, all in the same mode
  bankDecode ra1Dec (
    .regNum   (ra1Num),
    .zero     (ctrlD.zeroRa1),
    .mode     (cpsrModeW),
    .physAddr (addrD.ra1)
  );

  bankDecode ra2Dec (
    .regNum   (ra2Num),
    .zero     (ctrlD.zeroRa2),
    .mode     (cpsrModeW),
    .physAddr (addrD.ra2)
  );

  bankDecode wa3Dec (
    .regNum   (wa3Num),
    .zero     (ctrlD.zeroWa3),
    .mode     (cpsrModeW),
    .physAddr (addrD.wa3)
  );

  assign ra1D = addrD.ra1;
  assign ra2D = addrD.ra2;

  // ====================
  // Execute
  // ====================

  addrPipe pipe (
    .clk    (clk),
    .rst    (rst),
    .addrD  (addrD),
    .stallE (stallE),
    .stallM (stallM),
    .flushM (flushM),
    .stallW (stallW),
    .flushW (flushW),
    .addrE  (addrE),
    .wa3M   (),
    .wa3W   (wa3W)
  );

  // ====================
  // Result
  // ====================

  hazardMatch match (
    .clk      (clk),
    .rst      (rst),
    .stallM   (stallM),
    .flushM   (flushM),
    .addrD    (addrD),
    .addrE    (addrE),
    .wa3W     (wa3W),
    .match1DE (match1DE),
    .match2DE (match2DE),
    .match1EM (match1EM),
    .match2EM (match2EM),
    .match1EW (match1EW),
    .match2EW (match2EW)
  );

endmodule

/* hdl/bankDecode.sv */
`timescale 1ns/1ps

module bankDecode (
  input  logic [3:0]            regNum,
  input  logic                  zero,
  input  regBankPkg::modeT      mode,
  output regBankPkg::physAddrT  physAddr
);

  import regBankPkg::*;

  modeOneHotT modeHot;
  physIdxT    bankBase;
  physIdxT    physIdx;

  // ====================
  // Mode decode
  // ====================

  always_comb begin
    modeHot = '0;
    case (mode)
      ModeUsr, ModeSys: modeHot.userSys = 1'b1;
      ModeFiq:          modeHot.fiq     = 1'b1;
      ModeIrq:          modeHot.irq     = 1'b1;
      ModeSvc:          modeHot.svc     = 1'b1;
      ModeAbt:          modeHot.abort   = 1'b1;
      ModeUnd:          modeHot.undef   = 1'b1;
      // Unknown code falls back to user
      default:          modeHot.userSys = 1'b1;
    endcase
  end

  // SP and LR bank of the current mode
  always_comb begin
    bankBase = '0;
    if (modeHot.userSys) bankBase = UsrBankBase;
    if (modeHot.fiq) bankBase = FiqBankBase;
    if (modeHot.irq) bankBase = IrqBankBase;
    if (modeHot.svc) bankBase = SvcBankBase;
    if (modeHot.abort) bankBase = AbtBankBase;
    if (modeHot.undef) bankBase = UndBankBase;
  end

  // ====================
  // Physical index
  // ====================

  always_comb begin
    physIdx = {1'b0, regNum};
    if (regNum >= 4'd8 && regNum <= 4'd12) begin
      // r8 to r12 take low bits 0 to 4 as the fiq offset
      if (modeHot.fiq) begin
        physIdx = FiqHighBase + {2'b00, regNum[2:0]};
      end
    end else if (regNum == 4'd13) begin
      physIdx = bankBase;
    end else if (regNum == 4'd14) begin
      physIdx = bankBase + 5'd1;
    end
    // r0 to r7 and PC keep their own number
  end

  // One-hot line, unused port drives nothing
  assign physAddr = zero ? '0 : (physAddrT'(1) << physIdx);

endmodule

/* hdl/hazardMatch.sv */
`timescale 1ns/1ps

module hazardMatch (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stallM,
  input  logic                   flushM,
  input  regBankPkg::stageAddrT  addrD,
  input  regBankPkg::stageAddrT  addrE,
  input  regBankPkg::physAddrT   wa3W,
  output logic                   match1DE,
  output logic                   match2DE,
  output logic                   match1EM,
  output logic                   match2EM,
  output logic                   match1EW,
  output logic                   match2EW
);

  import regBankPkg::*;

  // Same line and some register selected
  function automatic logic lineMatch(physAddrT readLine, physAddrT writeLine);
    return (readLine == writeLine) && (|readLine);
  endfunction

  // ====================
  // Decode against E
  // ====================

  assign match1DE = lineMatch(addrD.ra1, addrE.wa3);
  // Immediate operand never collides
  assign match2DE = lineMatch(addrD.ra2, addrE.wa3) & addrD.regR2;

  // D to E result one stage on, same enable as the M stage
  always_ff @(posedge clk) begin
    if (rst) begin
      match1EM <= 1'b0;
      match2EM <= 1'b0;
    end else if (flushM) begin
      match1EM <= 1'b0;
      match2EM <= 1'b0;
    end else if (!stallM) begin
      match1EM <= match1DE;
      match2EM <= match2DE;
    end
  end

  // ====================
  // Execute against W
  // ====================

  assign match1EW = lineMatch(addrE.ra1, wa3W);
  assign match2EW = lineMatch(addrE.ra2, wa3W) & addrE.regR2;

endmodule

/* hdl/instrPkg.sv */
package instrPkg;

  // ====================
  // Encoding constants
  // ====================

  // Bits 7:4 of every multiply form
  localparam logic [3:0] MulMarker = 4'b1001;

  // Program counter as an architectural number
  localparam logic [3:0] PcRegNum = 4'hF;

  // ====================
  // Instruction views
  // ====================

  // Data-processing layout
  typedef struct packed {
    logic [3:0] cond;
    // Class, opcode, S bit
    logic [7:0] op;
    logic [3:0] rn;
    logic [3:0] rd;
    // Shift amount register in the RSR form
    logic [3:0] rs;
    // Shift type and RSR flag
    logic [3:0] shift;
    logic [3:0] rm;
  } dpFieldsT;

  // Multiply layout, Rd and Rn swap places
  typedef struct packed {
    logic [3:0] cond;
    // Bits 27:22 clear, then A and S
    logic [7:0] op;
    logic [3:0] rd;
    // Accumulate operand
    logic [3:0] rn;
    logic [3:0] rs;
    logic [3:0] marker;
    logic [3:0] rm;
  } mulFieldsT;

  // One word, two readings
  typedef union packed {
    dpFieldsT  dp;
    mulFieldsT mul;
  } instrWordT;

  // Strobes from the controller for the register ports
  typedef struct packed {
    // Operand 2 is an immediate
    logic       aluSrc;
    // Bit 0 forces Rn to PC, bit 1 reads Rd on port 2
    logic [1:0] regSrc;
    // Register-shifted register, port 1 reads Rs
    logic       rsr;
    // Port reads or writes no register
    logic       zeroRa1;
    logic       zeroRa2;
    logic       zeroWa3;
  } regCtrlT;

  // Multiply pattern, top of op field zero and marker present
  function automatic logic isMultiply(instrWordT word);
    return (word.mul.op[7:2] == 6'b000000) && (word.mul.marker == MulMarker);
  endfunction

endpackage

/* hdl/regBankPkg.sv */
package regBankPkg;

  // ====================
  // Processor modes
  // ====================

  // CPSR mode field, left as plain bits so odd codes can arrive
  typedef logic [4:0] modeT;

  localparam modeT ModeUsr = 5'b10000;
  localparam modeT ModeFiq = 5'b10001;
  localparam modeT ModeIrq = 5'b10010;
  localparam modeT ModeSvc = 5'b10011;
  localparam modeT ModeAbt = 5'b10111;
  localparam modeT ModeUnd = 5'b11011;
  localparam modeT ModeSys = 5'b11111;

  // Exactly one bit set after decode
  typedef struct packed {
    // User and system share a bank
    logic userSys;
    logic fiq;
    logic irq;
    logic svc;
    logic abort;
    logic undef;
  } modeOneHotT;

  // ====================
  // Physical registers
  // ====================

  localparam int PhysRegCount = 32;

  // Index into the physical file
  typedef logic [4:0] physIdxT;

  // One-hot select line for the register file
  typedef logic [PhysRegCount-1:0] physAddrT;

  // Shared low registers and PC sit at their own number
  // Fiq copies of r8 to r12
  localparam physIdxT FiqHighBase = 5'd16;

  // SP and LR pairs, LR at base plus one
  localparam physIdxT UsrBankBase = 5'd13;
  localparam physIdxT FiqBankBase = 5'd21;
  localparam physIdxT IrqBankBase = 5'd23;
  localparam physIdxT SvcBankBase = 5'd25;
  localparam physIdxT AbtBankBase = 5'd27;
  localparam physIdxT UndBankBase = 5'd29;

  // All lines of one instruction in a stage
  typedef struct packed {
    physAddrT ra1;
    physAddrT ra2;
    physAddrT wa3;
    // Port 2 holds a real register, not an immediate
    logic     regR2;
  } stageAddrT;

endpackage

/* hdl/regSelect.sv */
`timescale 1ns/1ps

module regSelect (
  input  instrPkg::instrWordT instrD,
  input  instrPkg::regCtrlT   ctrlD,
  output logic [3:0]          ra1Num,
  output logic [3:0]          ra2Num,
  output logic [3:0]          wa3Num,
  output logic                regR2
);

  import instrPkg::*;

  logic       mulD;
  logic [3:0] rnSel;
  logic [3:0] rdSel;
  logic [3:0] rsSel;
  logic [3:0] rmSel;
  logic [3:0] ra1Rn;

  // ====================
  // Field extraction
  // ====================

  assign mulD = isMultiply(instrD);

  // Multiply keeps Rd in 19:16 and Rn in 15:12
  always_comb begin
    if (mulD) begin
      rnSel = instrD.mul.rn;
      rdSel = instrD.mul.rd;
    end else begin
      rnSel = instrD.dp.rn;
      rdSel = instrD.dp.rd;
    end
  end

  // Rs and Rm sit at the same bits in both layouts
  assign rsSel = instrD.dp.rs;
  assign rmSel = instrD.dp.rm;

  // ====================
  // Port selection
  // ====================

  // PC as base for literal loads and branches
  assign ra1Rn = ctrlD.regSrc[0] ? PcRegNum : rnSel;

  // Shift amount register overrides the base
  assign ra1Num = ctrlD.rsr ? rsSel : ra1Rn;

  // Store data comes from Rd
  assign ra2Num = ctrlD.regSrc[1] ? rdSel : rmSel;

  assign wa3Num = rdSel;

  // Rm slot may hold immediate bits, so only a real Rm counts
  assign regR2 = ~mulD & ~ctrlD.regSrc[1] & ~ctrlD.aluSrc;

endmodule

/* tb/addressPathTb.sv */
`timescale 1ns/1ps

module addressPathTb;

  import instrPkg::*;
  import regBankPkg::*;

  // ====================
  // Run length
  // ====================

  localparam int ResetCycles       = 2;
  localparam int BankMapCycles     = 300;
  localparam int FieldSelectCycles = 300;
  localparam int PipeFlowCycles    = 400;
  localparam int HazardCycles      = 500;
  localparam int TimeoutCycles     = ResetCycles + BankMapCycles + FieldSelectCycles
                                     + PipeFlowCycles + HazardCycles + 100;

  logic      clk;
  logic      rst;
  instrWordT instrD;
  regCtrlT   ctrlD;
  modeT      cpsrModeW;
  logic      stallE;
  logic      stallM;
  logic      flushM;
  logic      stallW;
  logic      flushW;
  physAddrT  ra1D;
  physAddrT  ra2D;
  physAddrT  wa3W;
  logic      match1DE;
  logic      match2DE;
  logic      match1EM;
  logic      match2EM;
  logic      match1EW;
  logic      match2EW;

  // Shadow pipeline
  stageAddrT shE;
  physAddrT  shM;
  physAddrT  shW;
  logic      sh1EM;
  logic      sh2EM;

  int cycleCount;
  int checks;
  int errors;
  int testsRun;
  int testsFailed;

  addressPath dut_i (
    .clk       (clk),
    .rst       (rst),
    .instrD    (instrD),
    .ctrlD     (ctrlD),
    .cpsrModeW (cpsrModeW),
    .stallE    (stallE),
    .stallM    (stallM),
    .flushM    (flushM),
    .stallW    (stallW),
    .flushW    (flushW),
    .ra1D      (ra1D),
    .ra2D      (ra2D),
    .wa3W      (wa3W),
    .match1DE  (match1DE),
    .match2DE  (match2DE),
    .match1EM  (match1EM),
    .match2EM  (match2EM),
    .match1EW  (match1EW),
    .match2EW  (match2EW)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Hard stop well past the planned test length
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: run still going after %0d cycles", TimeoutCycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ====================
  // Reference model
  // ====================

  // Physical index from register number and mode
  function automatic logic [4:0] expIndex(logic [3:0] num, logic [4:0] mode);
    logic [4:0] spBase;
    logic       inFiq;
    inFiq = (mode == 5'b10001);
    case (mode)
      5'b10001: spBase = 5'd21;
      5'b10010: spBase = 5'd23;
      5'b10011: spBase = 5'd25;
      5'b10111: spBase = 5'd27;
      5'b11011: spBase = 5'd29;
      // user, sys and odd codes
      default:  spBase = 5'd13;
    endcase
    if (num <= 4'd7 || num == 4'd15) return {1'b0, num};
    if (num <= 4'd12) return inFiq ? ({1'b0, num} + 5'd8) : {1'b0, num};
    if (num == 4'd13) return spBase;
    return spBase + 5'd1;
  endfunction

  function automatic logic [31:0] expLine(logic [3:0] num, logic zeroSel, logic [4:0] mode);
    if (zeroSel) return 32'd0;
    return 32'd1 << expIndex(num, mode);
  endfunction

  // Port numbers and lines for one decode cycle
  function automatic stageAddrT expDecode(instrWordT word, regCtrlT c, modeT mode);
    logic [31:0] w;
    logic        mul;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [3:0]  n1;
    logic [3:0]  n2;
    stageAddrT   s;
    w = word;
    mul = (w[27:22] == 6'd0) && (w[7:4] == 4'b1001);
    rn = mul ? w[15:12] : w[19:16];
    rd = mul ? w[19:16] : w[15:12];
    n1 = c.rsr ? w[11:8] : (c.regSrc[0] ? 4'd15 : rn);
    n2 = c.regSrc[1] ? rd : w[3:0];
    s.ra1 = expLine(n1, c.zeroRa1, mode);
    s.ra2 = expLine(n2, c.zeroRa2, mode);
    s.wa3 = expLine(rd, c.zeroWa3, mode);
    s.regR2 = !mul && !c.regSrc[1] && !c.aluSrc;
    return s;
  endfunction

  function automatic logic expMatch(logic [31:0] rd, logic [31:0] wr);
    return (rd == wr) && (rd != 32'd0);
  endfunction

  // Shadow stages take the inputs held across this edge
  task automatic advanceModel();
    stageAddrT curD;
    logic      m1;
    logic      m2;
    curD = expDecode(instrD, ctrlD, cpsrModeW);
    m1 = expMatch(curD.ra1, shE.wa3);
    m2 = expMatch(curD.ra2, shE.wa3) && curD.regR2;
    if (rst) begin
      shE = '0;
      shM = '0;
      shW = '0;
      sh1EM = 1'b0;
      sh2EM = 1'b0;
    end else begin
      // W before M before E, each sees the old value upstream
      if (flushW) shW = '0;
      else if (!stallW) shW = shM;
      if (flushM) begin
        shM = '0;
        sh1EM = 1'b0;
        sh2EM = 1'b0;
      end else if (!stallM) begin
        shM = shE.wa3;
        sh1EM = m1;
        sh2EM = m2;
      end
      if (!stallE) shE = curD;
    end
  endtask

  // ====================
  // Stimulus
  // ====================

  // Collision-prone register set
  function automatic logic [3:0] poolReg();
    case ($urandom % 4)
      0:       return 4'd2;
      1:       return 4'd9;
      2:       return 4'd13;
      default: return 4'd14;
    endcase
  endfunction

  function automatic instrWordT randInstr(bit usePool);
    logic [31:0] w;
    w = $urandom;
    // Multiply shape one time in four
    if (($urandom % 4) == 0) begin
      w[27:22] = 6'd0;
      w[7:4] = 4'b1001;
    end
    if (usePool) begin
      w[19:16] = poolReg();
      w[15:12] = poolReg();
      w[11:8] = poolReg();
      w[3:0] = poolReg();
    end
    return w;
  endfunction

  function automatic regCtrlT randCtrl();
    regCtrlT c;
    c.aluSrc = 1'($urandom);
    c.regSrc = 2'($urandom);
    c.rsr = (($urandom % 4) == 0);
    c.zeroRa1 = (($urandom % 4) == 0);
    c.zeroRa2 = (($urandom % 4) == 0);
    c.zeroWa3 = (($urandom % 4) == 0);
    return c;
  endfunction

  // Kind 0 user only, 2 user or fiq, else all modes and odd codes
  function automatic modeT randMode(int kind);
    if (kind == 0) return 5'b10000;
    if (kind == 2) return (($urandom % 2) == 0) ? 5'b10000 : 5'b10001;
    case ($urandom % 9)
      0:       return 5'b10000;
      1:       return 5'b10001;
      2:       return 5'b10010;
      3:       return 5'b10011;
      4:       return 5'b10111;
      5:       return 5'b11011;
      6:       return 5'b11111;
      default: return 5'($urandom);
    endcase
  endfunction

  // High one time in rate, never for rate zero
  function automatic logic randLevel(int unsigned rate);
    if (rate == 0) return 1'b0;
    return ($urandom % rate) == 0;
  endfunction

  task automatic driveInputs(bit usePool, int modeKind, int unsigned stallRate,
                             int unsigned flushRate);
    instrD <= randInstr(usePool);
    ctrlD <= randCtrl();
    cpsrModeW <= randMode(modeKind);
    stallE <= randLevel(stallRate);
    stallM <= randLevel(stallRate);
    stallW <= randLevel(stallRate);
    flushM <= randLevel(flushRate);
    flushW <= randLevel(flushRate);
  endtask

  // ====================
  // Checks
  // ====================

  task automatic checkLine(string testName, string sigName, logic [31:0] expVal,
                           logic [31:0] actVal);
    checks++;
    assert (actVal === expVal) else begin
      $display("MISMATCH %s %s expected %h actual %h", testName, sigName, expVal, actVal);
      errors++;
    end
  endtask

  task automatic checkBit(string testName, string sigName, logic expVal, logic actVal);
    checks++;
    assert (actVal === expVal) else begin
      $display("MISMATCH %s %s expected %b actual %b", testName, sigName, expVal, actVal);
      errors++;
    end
  endtask

  // Sampled mid-cycle, away from the driving edge
  task automatic checkOutputs(string testName);
    stageAddrT expD;
    @(negedge clk);
    expD = expDecode(instrD, ctrlD, cpsrModeW);
    checkLine(testName, "ra1D", expD.ra1, ra1D);
    checkLine(testName, "ra2D", expD.ra2, ra2D);
    checkLine(testName, "wa3W", shW, wa3W);
    checkBit(testName, "match1DE", expMatch(expD.ra1, shE.wa3), match1DE);
    checkBit(testName, "match2DE", expMatch(expD.ra2, shE.wa3) && expD.regR2, match2DE);
    checkBit(testName, "match1EM", sh1EM, match1EM);
    checkBit(testName, "match2EM", sh2EM, match2EM);
    checkBit(testName, "match1EW", expMatch(shE.ra1, shW), match1EW);
    checkBit(testName, "match2EW", expMatch(shE.ra2, shW) && shE.regR2, match2EW);
  endtask

  task automatic clockEdge();
    @(posedge clk);
    advanceModel();
  endtask

  task automatic reportTest(string testName, int cycles, int checksAtStart, int errorsAtStart);
    testsRun++;
    if (errors != errorsAtStart) testsFailed++;
    $display("test %s: %0d cycles, %0d checks, %0d errors", testName, cycles,
             checks - checksAtStart, errors - errorsAtStart);
  endtask

  task automatic runTest(string testName, int cycles, bit usePool, int modeKind,
                         int unsigned stallRate, int unsigned flushRate);
    int checksAtStart;
    int errorsAtStart;
    checksAtStart = checks;
    errorsAtStart = errors;
    repeat (cycles) begin
      clockEdge();
      driveInputs(usePool, modeKind, stallRate, flushRate);
      checkOutputs(testName);
    end
    reportTest(testName, cycles, checksAtStart, errorsAtStart);
  endtask

  // ====================
  // Test sequence
  // ====================

  initial begin
    void'($urandom(93));
    rst = 1'b1;
    instrD = '0;
    ctrlD = '0;
    cpsrModeW = 5'b10000;
    stallE = 1'b0;
    stallM = 1'b0;
    flushM = 1'b0;
    stallW = 1'b0;
    flushW = 1'b0;
    cycleCount = 0;
    checks = 0;
    errors = 0;
    testsRun = 0;
    testsFailed = 0;
    shE = '0;
    shM = '0;
    shW = '0;
    sh1EM = 1'b0;
    sh2EM = 1'b0;

    // Two edges in reset, then release
    clockEdge();
    clockEdge();
    rst <= 1'b0;
    checkOutputs("reset");
    reportTest("reset", ResetCycles, 0, 0);

    // All modes, no stalls, wa3 reaches W three edges later
    runTest("bankMap", BankMapCycles, 1'b0, 1, 0, 0);
    // User mode keeps the line a plain image of the port number
    runTest("fieldSelect", FieldSelectCycles, 1'b0, 0, 0, 0);
    // Stall and flush often enough to overlap
    runTest("pipeFlow", PipeFlowCycles, 1'b0, 1, 3, 4);
    runTest("hazardMatches", HazardCycles, 1'b1, 2, 5, 8);

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors", testsRun,
             testsFailed, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
